// ==== rtl/mem_pipe_config.svh ====
`ifndef MEM_PIPE_CONFIG_SVH
`define MEM_PIPE_CONFIG_SVH

// address and data path width
`define MEM_PIPE_XLEN 32

// number of direct-mapped windows
`define MEM_PIPE_DMW_COUNT 2

// architectural register index width
`define MEM_PIPE_REG_W 5

// andi r0, r0, 0
`define MEM_PIPE_INST_NOP 32'h0340_0000

`endif

// ==== rtl/mem_pipe_pkg.sv ====
`default_nettype none

`include "mem_pipe_config.svh"

package mem_pipe_pkg;

    typedef enum logic [0:0] {
        op_load  = 1'b0,
        op_store = 1'b1
    } mem_op_e;

    typedef enum logic [1:0] {
        size_byte = 2'd0,
        size_half = 2'd1,
        size_word = 2'd2
    } mem_size_e;

    // ecode values as carried in estat
    typedef enum logic [6:0] {
        excp_none = 7'h00,
        excp_ale  = 7'h09,
        excp_tlbr = 7'h3f
    } excp_code_e;

    typedef struct packed {
        logic [`MEM_PIPE_XLEN-1:0]  pc;
        logic [`MEM_PIPE_XLEN-1:0]  inst;
        logic [`MEM_PIPE_XLEN-1:0]  rj_data;
        logic [`MEM_PIPE_XLEN-1:0]  rk_data;
        logic [`MEM_PIPE_XLEN-1:0]  imm;
        logic [`MEM_PIPE_REG_W-1:0] rd;
        mem_op_e                    op;
        mem_size_e                  size;
        logic                       is_atom;
    } issue_pkt_t;

    // vseg/pseg are the top three address bits
    typedef struct packed {
        logic       en;
        logic [2:0] vseg;
        logic [2:0] pseg;
    } dmw_t;

    typedef struct packed {
        mem_op_e                   op;
        logic [3:0]                strb;
        logic [`MEM_PIPE_XLEN-1:0] paddr;
        logic [`MEM_PIPE_XLEN-1:0] wdata;
        logic                      is_atom;
    } dcache_req_t;

    typedef struct packed {
        dcache_req_t               req;
        logic [`MEM_PIPE_XLEN-1:0] badv;
        excp_code_e                excp;
    } xlate_res_t;

    typedef struct packed {
        logic [`MEM_PIPE_XLEN-1:0]  pc;
        logic [`MEM_PIPE_XLEN-1:0]  inst;
        logic [`MEM_PIPE_REG_W-1:0] rd;
        dcache_req_t                req;
        logic [`MEM_PIPE_XLEN-1:0]  badv;
        excp_code_e                 excp;
    } ex1_pkt_t;

endpackage

`default_nettype wire

// ==== rtl/dmw_regs.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mem_pipe_config.svh"

module dmw_regs (
    input  wire                                         clk,
    input  wire                                         aresetn,
    input  wire                                         cfg_wr,
    input  wire                                         cfg_idx,
    input  wire  mem_pipe_pkg::dmw_t                    cfg_data,
    output mem_pipe_pkg::dmw_t [`MEM_PIPE_DMW_COUNT-1:0] dmw
);

    // all windows off out of reset, so every access misses
    always_ff @(posedge clk) begin
        if (!aresetn) begin
            dmw <= '0;
        end else if (cfg_wr) begin
            dmw[cfg_idx] <= cfg_data;
        end
    end

    // strobe must address an existing window
    cfg_idx_in_range: assert property (
        @(posedge clk) disable iff (!aresetn)
        cfg_wr |-> (int'(cfg_idx) < `MEM_PIPE_DMW_COUNT)
    ) else $error("cfg_idx %0d out of range", cfg_idx);

endmodule

`default_nettype wire

// ==== rtl/addr_translate.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mem_pipe_config.svh"

module addr_translate (
    input  wire  mem_pipe_pkg::issue_pkt_t                      in_pkt,
    input  wire  mem_pipe_pkg::dmw_t [`MEM_PIPE_DMW_COUNT-1:0]  dmw,
    output mem_pipe_pkg::xlate_res_t                             res
);

    logic [`MEM_PIPE_XLEN-1:0] vaddr;
    logic                      hit;
    logic [2:0]                pseg;
    logic                      misalign;
    logic [3:0]                strb_base;
    mem_pipe_pkg::excp_code_e  excp;

    assign vaddr = in_pkt.rj_data + in_pkt.imm;

    // lowest enabled window wins on overlap
    always_comb begin
        hit  = 1'b0;
        pseg = 3'b000;
        for (int i = 0; i < `MEM_PIPE_DMW_COUNT; i++) begin
            if (!hit && dmw[i].en && (dmw[i].vseg == vaddr[`MEM_PIPE_XLEN-1 -: 3])) begin
                hit  = 1'b1;
                pseg = dmw[i].pseg;
            end
        end
    end

    always_comb begin
        case (in_pkt.size)
            mem_pipe_pkg::size_half: begin
                misalign  = vaddr[0];
                strb_base = 4'b0011;
            end
            mem_pipe_pkg::size_word: begin
                misalign  = |vaddr[1:0];
                strb_base = 4'b1111;
            end
            default: begin
                misalign  = 1'b0;
                strb_base = 4'b0001;
            end
        endcase
    end

    // alignment fault outranks a window miss
    always_comb begin
        if (misalign) begin
            excp = mem_pipe_pkg::excp_ale;
        end else if (!hit) begin
            excp = mem_pipe_pkg::excp_tlbr;
        end else begin
            excp = mem_pipe_pkg::excp_none;
        end
    end

    always_comb begin
        res.req.op      = in_pkt.op;
        res.req.paddr   = {pseg, vaddr[`MEM_PIPE_XLEN-4:0]};
        res.req.wdata   = in_pkt.rk_data;
        res.req.is_atom = in_pkt.is_atom;
        res.badv        = vaddr;
        res.excp        = excp;
        if (excp == mem_pipe_pkg::excp_none) begin
            res.req.strb = 4'(strb_base << vaddr[1:0]);
        end else begin
            res.req.strb = 4'b0000;
        end
    end

    // a faulting access must not touch any byte lane in the dcache
    always_comb begin
        if (res.excp != mem_pipe_pkg::excp_none) begin
            assert (res.req.strb == 4'b0000)
                else $error("strb %b on exception %h", res.req.strb, res.excp);
        end
    end

endmodule

`default_nettype wire

// ==== rtl/mem_stage_buffer.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mem_pipe_config.svh"

module mem_stage_buffer (
    input  wire                            clk,
    input  wire                            aresetn,
    input  wire                            flush,
    input  wire                            flush_by_exception,
    input  wire                            forward_stall,
    input  wire                            ex_allowin,
    input  wire                            in_valid,
    input  wire  mem_pipe_pkg::issue_pkt_t in_pkt,
    input  wire  mem_pipe_pkg::xlate_res_t xres,
    output logic                           in_allowin,
    output logic                           ex_readygo,
    output logic                           out_valid,
    output mem_pipe_pkg::ex1_pkt_t         out_pkt
);

    logic started;
    logic excp_hold;
    logic excp_pending;
    logic accept;
    logic clear;

    // exception already sitting in the register toward ex1
    assign excp_pending = (out_pkt.excp != mem_pipe_pkg::excp_none);

    assign in_allowin = started & ex_allowin & ~excp_pending & ~excp_hold;
    assign accept     = in_valid & in_allowin;
    assign clear      = (flush & ex_allowin) | flush_by_exception;
    assign ex_readygo = ~forward_stall;

    // keeps the input closed for the first cycle out of reset
    always_ff @(posedge clk) begin
        if (!aresetn) begin
            started <= 1'b0;
        end else begin
            started <= 1'b1;
        end
    end

    // stage register, held while ex1 is not ready
    always_ff @(posedge clk) begin
        if (!aresetn || clear) begin
            out_valid    <= 1'b0;
            out_pkt      <= '0;
            out_pkt.inst <= `MEM_PIPE_INST_NOP;
        end else if (ex_allowin) begin
            out_valid <= accept;
            if (accept) begin
                out_pkt.pc   <= in_pkt.pc;
                out_pkt.inst <= in_pkt.inst;
                out_pkt.rd   <= in_pkt.rd;
                out_pkt.req  <= xres.req;
                out_pkt.badv <= xres.badv;
                out_pkt.excp <= xres.excp;
            end
        end
    end

    // set once the exception has gone out, dropped by the exception flush
    always_ff @(posedge clk) begin
        if (!aresetn || flush_by_exception) begin
            excp_hold <= 1'b0;
        end else if (out_valid && excp_pending) begin
            excp_hold <= 1'b1;
        end
    end

    // nothing valid toward ex1 straight out of reset
    out_valid_after_reset: assert property (
        @(posedge clk)
        !aresetn |=> !out_valid
    ) else $error("out_valid high after reset");

    // input stays fenced while an exception is outstanding
    hold_blocks_input: assert property (
        @(posedge clk) disable iff (!aresetn)
        excp_hold |-> !in_allowin
    ) else $error("in_allowin high during exception hold");

endmodule

`default_nettype wire

// ==== rtl/mem_pipe_top.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mem_pipe_config.svh"

module mem_pipe_top (
    input  wire                              clk,
    input  wire                              aresetn,
    input  wire                              cfg_wr,
    input  wire                              cfg_idx,
    input  wire  mem_pipe_pkg::dmw_t         cfg_data,
    input  wire                              in_valid,
    input  wire  mem_pipe_pkg::issue_pkt_t   in_pkt,
    output logic                             in_allowin,
    input  wire                              flush,
    input  wire                              flush_by_exception,
    input  wire                              forward_stall,
    input  wire                              ex_allowin,
    output logic                             ex_readygo,
    output logic                             out_valid,
    output mem_pipe_pkg::ex1_pkt_t           out_pkt,
    output logic                             dcache_valid,
    output mem_pipe_pkg::dcache_req_t        dcache_req
);

    mem_pipe_pkg::dmw_t [`MEM_PIPE_DMW_COUNT-1:0] dmw;
    mem_pipe_pkg::xlate_res_t                     xres;

    dmw_regs dmw_regs_i (
        .clk      (clk),
        .aresetn  (aresetn),
        .cfg_wr   (cfg_wr),
        .cfg_idx  (cfg_idx),
        .cfg_data (cfg_data),
        .dmw      (dmw)
    );

    addr_translate addr_translate_i (
        .in_pkt (in_pkt),
        .dmw    (dmw),
        .res    (xres)
    );

    mem_stage_buffer mem_stage_buffer_i (
        .clk                (clk),
        .aresetn            (aresetn),
        .flush              (flush),
        .flush_by_exception (flush_by_exception),
        .forward_stall      (forward_stall),
        .ex_allowin         (ex_allowin),
        .in_valid           (in_valid),
        .in_pkt             (in_pkt),
        .xres               (xres),
        .in_allowin         (in_allowin),
        .ex_readygo         (ex_readygo),
        .out_valid          (out_valid),
        .out_pkt            (out_pkt)
    );

    // dcache sees the request on the cycle the packet is taken
    assign dcache_valid = in_valid & in_allowin;
    assign dcache_req   = xres.req;

endmodule

`default_nettype wire

// ==== verif/mem_pipe_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mem_pipe_config.svh"

module mem_pipe_tb;

    typedef struct packed {
        mem_pipe_pkg::mem_op_e     op;
        mem_pipe_pkg::mem_size_e   size;
        logic [`MEM_PIPE_XLEN-1:0] rj_data;
        logic [`MEM_PIPE_XLEN-1:0] imm;
        logic [`MEM_PIPE_XLEN-1:0] rk_data;
        int                        wait_cycles;
        logic                      expect_excp;
        logic                      write_win1;
    } stim_t;

    localparam int WAIT_LIMIT = 20;

    logic                      clk = 1'b0;
    logic                      aresetn;
    logic                      cfg_wr;
    logic                      cfg_idx;
    mem_pipe_pkg::dmw_t        cfg_data;
    logic                      in_valid;
    mem_pipe_pkg::issue_pkt_t  in_pkt;
    logic                      in_allowin;
    logic                      flush;
    logic                      flush_by_exception;
    logic                      forward_stall;
    logic                      ex_allowin;
    logic                      ex_readygo;
    logic                      out_valid;
    mem_pipe_pkg::ex1_pkt_t    out_pkt;
    logic                      dcache_valid;
    mem_pipe_pkg::dcache_req_t dcache_req;

    // testbench copy of the window registers
    mem_pipe_pkg::dmw_t win_model [`MEM_PIPE_DMW_COUNT];
    stim_t              stim_q [$];
    logic [31:0]        rng_state;

    always #10 clk = ~clk;

    mem_pipe_top mem_pipe_top_i (
        .clk                (clk),
        .aresetn            (aresetn),
        .cfg_wr             (cfg_wr),
        .cfg_idx            (cfg_idx),
        .cfg_data           (cfg_data),
        .in_valid           (in_valid),
        .in_pkt             (in_pkt),
        .in_allowin         (in_allowin),
        .flush              (flush),
        .flush_by_exception (flush_by_exception),
        .forward_stall      (forward_stall),
        .ex_allowin         (ex_allowin),
        .ex_readygo         (ex_readygo),
        .out_valid          (out_valid),
        .out_pkt            (out_pkt),
        .dcache_valid       (dcache_valid),
        .dcache_req         (dcache_req)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR %0t: %s is %b, expected %b", $time, name, got, exp);
            abort_run("control flag mismatch");
        end
    endtask

    task automatic check_excp(input string name, input mem_pipe_pkg::excp_code_e got,
                              input mem_pipe_pkg::excp_code_e exp);
        if (got !== exp) begin
            $display("ERROR %0t: %s is %h, expected %h", $time, name, got, exp);
            abort_run("exception code mismatch");
        end
    endtask

    task automatic check_req(input string name, input mem_pipe_pkg::dcache_req_t got,
                             input mem_pipe_pkg::dcache_req_t exp);
        if (got !== exp) begin
            $display("ERROR %0t: %s is %h, expected %h", $time, name, got, exp);
            abort_run("dcache request mismatch");
        end
    endtask

    task automatic check_pkt(input string name, input mem_pipe_pkg::ex1_pkt_t got,
                             input mem_pipe_pkg::ex1_pkt_t exp);
        if (got !== exp) begin
            $display("ERROR %0t: %s is %h, expected %h", $time, name, got, exp);
            abort_run("ex1 packet mismatch");
        end
    endtask

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic mem_pipe_pkg::ex1_pkt_t nop_pkt();
        mem_pipe_pkg::ex1_pkt_t f;
        f = '0;
        f.inst = `MEM_PIPE_INST_NOP;
        return f;
    endfunction

    // reference translation built from the address rules
    function automatic mem_pipe_pkg::xlate_res_t expect_xlate(
        input mem_pipe_pkg::issue_pkt_t p);
        mem_pipe_pkg::xlate_res_t  r;
        logic [`MEM_PIPE_XLEN-1:0] va;
        logic [2:0]                seg;
        logic                      hit;
        logic                      bad_align;
        logic [3:0]                lanes;
        va = p.rj_data + p.imm;
        hit = 1'b0;
        seg = 3'b000;
        // scan downward so the first matching window is the one kept
        for (int i = `MEM_PIPE_DMW_COUNT - 1; i >= 0; i--) begin
            if (win_model[i].en && win_model[i].vseg == va[`MEM_PIPE_XLEN-1 -: 3]) begin
                hit = 1'b1;
                seg = win_model[i].pseg;
            end
        end
        case (p.size)
            mem_pipe_pkg::size_byte: begin
                bad_align = 1'b0;
                lanes = 4'b0001;
            end
            mem_pipe_pkg::size_half: begin
                bad_align = va[0];
                lanes = 4'b0011;
            end
            default: begin
                bad_align = (va[1:0] != 2'b00);
                lanes = 4'b1111;
            end
        endcase
        r.req.op = p.op;
        r.req.paddr = {seg, va[`MEM_PIPE_XLEN-4:0]};
        r.req.wdata = p.rk_data;
        r.req.is_atom = p.is_atom;
        r.badv = va;
        if (bad_align) begin
            r.excp = mem_pipe_pkg::excp_ale;
        end else if (!hit) begin
            r.excp = mem_pipe_pkg::excp_tlbr;
        end else begin
            r.excp = mem_pipe_pkg::excp_none;
        end
        r.req.strb = (r.excp == mem_pipe_pkg::excp_none) ? (lanes << va[1:0]) : 4'b0000;
        return r;
    endfunction

    task automatic write_window(input logic idx, input mem_pipe_pkg::dmw_t w);
        cfg_wr = 1'b1;
        cfg_idx = idx;
        cfg_data = w;
        @(posedge clk);
        #1;
        cfg_wr = 1'b0;
        win_model[idx] = w;
    endtask

    // ordinary flush empties the register but the hold keeps the input shut
    task automatic hold_until_flush(input int cycles);
        in_valid = 1'b1;
        #1;
        check_bit("in_allowin", in_allowin, 1'b0);
        for (int n = 0; n < cycles; n++) begin
            @(posedge clk);
            #1;
            flush = (n == 0);
            #1;
            check_bit("in_allowin", in_allowin, 1'b0);
            check_bit("dcache_valid", dcache_valid, 1'b0);
            check_bit("out_valid", out_valid, 1'b0);
        end
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        flush = 1'b0;
        flush_by_exception = 1'b1;
        @(posedge clk);
        #1;
        flush_by_exception = 1'b0;
        check_bit("out_valid", out_valid, 1'b0);
        check_bit("in_allowin", in_allowin, 1'b1);
        check_pkt("out_pkt", out_pkt, nop_pkt());
    endtask

    task automatic stall_output(input int cycles, input mem_pipe_pkg::ex1_pkt_t held);
        if (cycles > 0) begin
            ex_allowin = 1'b0;
            #1;
            check_bit("in_allowin", in_allowin, 1'b0);
            for (int n = 0; n < cycles; n++) begin
                @(posedge clk);
                #2;
                check_bit("out_valid", out_valid, 1'b1);
                check_pkt("out_pkt", out_pkt, held);
                check_bit("in_allowin", in_allowin, 1'b0);
            end
            @(posedge clk);
            #1;
            ex_allowin = 1'b1;
        end
    endtask

    task automatic run_entry(input int idx, input stim_t s);
        mem_pipe_pkg::issue_pkt_t p;
        mem_pipe_pkg::xlate_res_t x;
        mem_pipe_pkg::ex1_pkt_t   e;
        int                       waited;
        rng_state = lcg_step(rng_state);
        p.pc = rng_state;
        rng_state = lcg_step(rng_state);
        p.inst = rng_state;
        p.rd = rng_state[`MEM_PIPE_REG_W-1:0];
        p.is_atom = rng_state[9];
        p.rj_data = s.rj_data;
        p.rk_data = s.rk_data;
        p.imm = s.imm;
        p.op = s.op;
        p.size = s.size;
        x = expect_xlate(p);
        if ((x.excp != mem_pipe_pkg::excp_none) != s.expect_excp) begin
            abort_run($sformatf("table entry %0d has the wrong exception flag", idx));
        end
        in_pkt = p;
        in_valid = 1'b1;
        waited = 0;
        #1;
        while (!in_allowin) begin
            if (waited == WAIT_LIMIT) begin
                abort_run("timed out waiting for in_allowin");
            end
            @(posedge clk);
            #2;
            waited++;
        end
        check_bit("dcache_valid", dcache_valid, 1'b1);
        check_req("dcache_req", dcache_req, x.req);
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        e.pc = p.pc;
        e.inst = p.inst;
        e.rd = p.rd;
        e.req = x.req;
        e.badv = x.badv;
        e.excp = x.excp;
        check_bit("out_valid", out_valid, 1'b1);
        check_excp("out_pkt.excp", out_pkt.excp, x.excp);
        check_pkt("out_pkt", out_pkt, e);
        if (x.excp != mem_pipe_pkg::excp_none) begin
            hold_until_flush(s.wait_cycles);
        end else begin
            stall_output(s.wait_cycles, e);
        end
    endtask

    task automatic add_entry(input mem_pipe_pkg::mem_op_e op, input mem_pipe_pkg::mem_size_e size,
                             input logic [31:0] rj, input logic [31:0] imm, input logic [31:0] rk,
                             input int waits, input logic excp, input logic win1);
        stim_t s;
        s.op = op;
        s.size = size;
        s.rj_data = rj;
        s.imm = imm;
        s.rk_data = rk;
        s.wait_cycles = waits;
        s.expect_excp = excp;
        s.write_win1 = win1;
        stim_q.push_back(s);
    endtask

    // op, size, rj, imm, rk, wait cycles, exception, enable window 1 first
    task automatic build_table();
        add_entry(mem_pipe_pkg::op_load, mem_pipe_pkg::size_word,
                  32'h8000_1000, 32'h0000_0010, 32'h0, 0, 1'b0, 1'b0);
        add_entry(mem_pipe_pkg::op_store, mem_pipe_pkg::size_byte,
                  32'h8000_2003, 32'h0, 32'hdead_beef, 2, 1'b0, 1'b0);
        add_entry(mem_pipe_pkg::op_store, mem_pipe_pkg::size_half,
                  32'h9000_0000, 32'h2, 32'h1234_5678, 0, 1'b0, 1'b0);
        add_entry(mem_pipe_pkg::op_load, mem_pipe_pkg::size_byte,
                  32'h8000_0000, 32'h1, 32'h0, 0, 1'b0, 1'b0);
        add_entry(mem_pipe_pkg::op_load, mem_pipe_pkg::size_half,
                  32'h8000_0001, 32'h0, 32'h0, 3, 1'b1, 1'b0);
        add_entry(mem_pipe_pkg::op_store, mem_pipe_pkg::size_word,
                  32'h8000_0002, 32'h0, 32'hcafe_f00d, 0, 1'b1, 1'b0);
        add_entry(mem_pipe_pkg::op_load, mem_pipe_pkg::size_word,
                  32'hc000_0000, 32'h4, 32'h0, 2, 1'b1, 1'b0);
        add_entry(mem_pipe_pkg::op_store, mem_pipe_pkg::size_half,
                  32'h0000_0003, 32'h0, 32'h0, 1, 1'b1, 1'b0);
        add_entry(mem_pipe_pkg::op_load, mem_pipe_pkg::size_word,
                  32'hc000_0000, 32'h8, 32'h0, 1, 1'b0, 1'b1);
        add_entry(mem_pipe_pkg::op_store, mem_pipe_pkg::size_half,
                  32'hdfff_fff0, 32'he, 32'h0000_abcd, 0, 1'b0, 1'b0);
        add_entry(mem_pipe_pkg::op_store, mem_pipe_pkg::size_word,
                  32'h8000_0100, 32'hffff_fffc, 32'h1357_9bdf, 0, 1'b0, 1'b0);
    endtask

    initial begin
        aresetn = 1'b0;
        cfg_wr = 1'b0;
        cfg_idx = 1'b0;
        cfg_data = '0;
        in_valid = 1'b0;
        in_pkt = '0;
        flush = 1'b0;
        flush_by_exception = 1'b0;
        forward_stall = 1'b0;
        ex_allowin = 1'b1;
        rng_state = 32'hcc9697d6;
        foreach (win_model[i]) win_model[i] = '0;
        build_table();
        repeat (2) @(posedge clk);
        #1;
        aresetn = 1'b1;
        #1;
        check_bit("out_valid", out_valid, 1'b0);
        check_bit("in_allowin", in_allowin, 1'b0);
        check_bit("dcache_valid", dcache_valid, 1'b0);
        @(posedge clk);
        #1;
        check_bit("in_allowin", in_allowin, 1'b1);
        forward_stall = 1'b1;
        #1;
        check_bit("ex_readygo", ex_readygo, 1'b0);
        @(posedge clk);
        #1;
        forward_stall = 1'b0;
        #1;
        check_bit("ex_readygo", ex_readygo, 1'b1);
        @(posedge clk);
        #1;
        // window 0 maps segment 4 onto segment 0, window 1 starts off
        write_window(1'b0, {1'b1, 3'h4, 3'h0});
        write_window(1'b1, {1'b0, 3'h6, 3'h2});
        foreach (stim_q[i]) begin
            if (stim_q[i].write_win1) begin
                write_window(1'b1, {1'b1, 3'h6, 3'h2});
            end
            run_entry(i, stim_q[i]);
        end
        // last entry is still in the register
        flush = 1'b1;
        @(posedge clk);
        #1;
        flush = 1'b0;
        check_bit("out_valid", out_valid, 1'b0);
        check_pkt("out_pkt", out_pkt, nop_pkt());
        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+rtl
rtl/mem_pipe_pkg.sv
rtl/dmw_regs.sv
rtl/addr_translate.sv
rtl/mem_stage_buffer.sv
rtl/mem_pipe_top.sv
verif/mem_pipe_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module mem_pipe_tb -f list.f -o mem_pipe_sim &&
./obj_dir/mem_pipe_sim ||
{ echo "simulation failed"; exit 1; }
